//--- verilog/tex_cache_defines.svh
`ifndef TEX_CACHE_DEFINES_SVH
`define TEX_CACHE_DEFINES_SVH

// ----------------------------------------
// texel and RAM word
// ----------------------------------------
`define TEX_TEXEL_W 24
`define TEX_WORD_TEXELS 2

// ----------------------------------------
// cache line addressing
// ----------------------------------------
// 64 lines of 4x4 texels
`define TEX_TAG_W 6
`define TEX_PIX_W 4
`define TEX_WORD_IDX_W 3

// coordinates 32..63 lie outside the texture
`define TEX_COORD_W 6
`define TEX_USER_W 8

`endif

//--- verilog/tex_cache_pkg.sv
`include "tex_cache_defines.svh"

package tex_cache_pkg;

	typedef logic [`TEX_TEXEL_W-1:0] texel_t;
	typedef logic [`TEX_TEXEL_W*`TEX_WORD_TEXELS-1:0] word_t;
	typedef logic [`TEX_TAG_W-1:0] tag_t;
	// row in [3:2], column in [1:0]
	typedef logic [`TEX_PIX_W-1:0] pix_t;
	typedef logic [`TEX_COORD_W-1:0] coord_t;
	typedef logic [`TEX_USER_W-1:0] user_t;

	// request into the cache RAM port
	typedef struct packed {
		user_t user;
		logic  border;
		logic  we;
		word_t wdata;
		tag_t  tag;
		pix_t  pix;
	} cache_req_t;

	// read response
	typedef struct packed {
		user_t  user;
		logic   border;
		texel_t data;
	} cache_rsp_t;

	// side favoured on the next contested cycle
	typedef enum logic {
		PRI_FILL,
		PRI_FETCH
	} arb_pri_e;

endpackage

//--- verilog/tex_line_fill.sv
`timescale 1ns/1ps
`include "tex_cache_defines.svh"

module tex_line_fill (
	input  logic                     clk,
	input  logic                     reset,
	input  tex_cache_pkg::tag_t       fill_tag,
	input  tex_cache_pkg::word_t      fill_data,
	input  logic                     fill_valid,
	output logic                     fill_ready,
	output tex_cache_pkg::cache_req_t wr_req,
	output logic                     wr_valid,
	input  logic                     wr_ready,
	output logic                     line_done
);
	import tex_cache_pkg::*;

	logic [`TEX_WORD_IDX_W-1:0] word_idx;
	logic beat;

	assign wr_valid = fill_valid;
	assign fill_ready = wr_ready;
	assign beat = fill_valid && wr_ready;

	// each word holds two texels, so word index maps to pix[3:1]
	always_comb begin
		wr_req = '0;
		wr_req.we = 1'b1;
		wr_req.wdata = fill_data;
		wr_req.tag = fill_tag;
		wr_req.pix = {word_idx, 1'b0};
	end

	// ----------------------------------------
	// word counter within a line
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			word_idx <= '0;
			line_done <= 1'b0;
		end else begin
			line_done <= beat && (&word_idx);
			if (beat) begin
				// wraps to zero after the last word
				word_idx <= word_idx + 1'b1;
			end
		end
	end

endmodule

//--- verilog/texel_fetch.sv
`timescale 1ns/1ps
`include "tex_cache_defines.svh"

module texel_fetch (
	input  logic                     clk,
	input  logic                     reset,
	input  tex_cache_pkg::coord_t     req_u,
	input  tex_cache_pkg::coord_t     req_v,
	input  tex_cache_pkg::user_t      req_user,
	input  logic                     req_valid,
	output logic                     req_ready,
	output tex_cache_pkg::cache_req_t rd_req,
	output logic                     rd_valid,
	input  logic                     rd_ready
);
	import tex_cache_pkg::*;

	cache_req_t next_req;
	logic out_of_range;

	// top coordinate bit set means 32 or more
	assign out_of_range = req_u[`TEX_COORD_W-1] || req_v[`TEX_COORD_W-1];

	// ----------------------------------------
	// address mapping
	// ----------------------------------------
	always_comb begin
		next_req = '0;
		next_req.user = req_user;
		next_req.border = out_of_range;
		next_req.we = 1'b0;
		// block row and column
		next_req.tag = {req_v[`TEX_COORD_W-2:2], req_u[`TEX_COORD_W-2:2]};
		// texel row and column inside the block
		next_req.pix = {req_v[1:0], req_u[1:0]};
	end

	// free slot or slot draining this cycle
	assign req_ready = !rd_valid || rd_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_valid <= 1'b0;
		end else if (req_ready) begin
			rd_valid <= req_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (req_valid && req_ready) begin
			rd_req <= next_req;
		end
	end

endmodule

//--- verilog/tex_cache_arbiter.sv
`timescale 1ns/1ps

module tex_cache_arbiter (
	input  logic                     clk,
	input  logic                     reset,
	input  tex_cache_pkg::cache_req_t fill_req,
	input  logic                     fill_valid,
	output logic                     fill_ready,
	input  tex_cache_pkg::cache_req_t fetch_req,
	input  logic                     fetch_valid,
	output logic                     fetch_ready,
	output tex_cache_pkg::cache_req_t mem_req,
	output logic                     mem_valid,
	input  logic                     mem_ready
);
	import tex_cache_pkg::*;

	arb_pri_e pri;
	logic contested;
	logic grant_fill;

	assign contested = fill_valid && fetch_valid;

	// a lone requester always wins
	always_comb begin
		if (contested) begin
			grant_fill = (pri == PRI_FILL);
		end else begin
			grant_fill = fill_valid;
		end
	end

	// ----------------------------------------
	// round-robin state
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			pri <= PRI_FILL;
		end else if (contested && mem_ready) begin
			case (pri)
				PRI_FILL: pri <= PRI_FETCH;
				PRI_FETCH: pri <= PRI_FILL;
				default: pri <= PRI_FILL;
			endcase
		end
	end

	assign mem_valid = fill_valid || fetch_valid;
	assign mem_req = grant_fill ? fill_req : fetch_req;

	// ready goes back to the winner only
	assign fill_ready = mem_ready && grant_fill;
	assign fetch_ready = mem_ready && fetch_valid && !grant_fill;

	// after a contested grant the other side wins the next contested cycle
	assert property (@(posedge clk) disable iff (reset)
		contested && mem_ready |=> !contested || (grant_fill != $past(grant_fill)));

endmodule

//--- verilog/tex_cache_mem.sv
`timescale 1ns/1ps
`include "tex_cache_defines.svh"

module tex_cache_mem (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     endian,
	input  tex_cache_pkg::texel_t     border_value,
	input  tex_cache_pkg::cache_req_t s_req,
	input  logic                     s_valid,
	output logic                     s_ready,
	output tex_cache_pkg::cache_rsp_t m_rsp,
	output logic                     m_valid,
	input  logic                     m_ready,
	output logic                     busy
);
	import tex_cache_pkg::*;

	logic cke;
	logic [`TEX_TAG_W+`TEX_WORD_IDX_W-1:0] addr;

	word_t ram [0:(1 << (`TEX_TAG_W + `TEX_WORD_IDX_W)) - 1];
	word_t ram_rd;
	word_t ram_q;

	// read flags, only reads travel as valid items
	logic st1_rd;
	logic st2_rd;
	logic st3_rd;

	user_t st1_user;
	user_t st2_user;
	logic st1_border;
	logic st2_border;
	logic st1_sel;
	logic st2_sel;

	texel_t half;
	cache_rsp_t st3_rsp;

	cache_rsp_t rsp_q;
	logic rsp_valid;

	// whole pipe moves only when the output slot can take a new item
	assign cke = !rsp_valid || m_ready;
	assign s_ready = cke;

	// word address, pix[0] picks the texel within the word
	assign addr = {s_req.tag, s_req.pix[`TEX_PIX_W-1:1]};

	// ----------------------------------------
	// cache RAM, read-first single port
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (cke) begin
			if (s_valid && s_req.we) begin
				ram[addr] <= s_req.wdata;
			end
			ram_rd <= ram[addr];
			// RAM output register
			ram_q <= ram_rd;
		end
	end

	// endian swaps which half counts as the lower texel
	always_comb begin
		if (st2_sel ^ endian) begin
			half = ram_q[2*`TEX_TEXEL_W-1:`TEX_TEXEL_W];
		end else begin
			half = ram_q[`TEX_TEXEL_W-1:0];
		end
	end

	// ----------------------------------------
	// stage control
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			st1_rd <= 1'b0;
			st2_rd <= 1'b0;
			st3_rd <= 1'b0;
			rsp_valid <= 1'b0;
		end else if (cke) begin
			st1_rd <= s_valid && !s_req.we;
			st2_rd <= st1_rd;
			st3_rd <= st2_rd;
			rsp_valid <= st3_rd;
		end
	end

	// sideband and data
	always_ff @(posedge clk) begin
		if (cke) begin
			st1_user <= s_req.user;
			st1_border <= s_req.border;
			st1_sel <= s_req.pix[0];
			st2_user <= st1_user;
			st2_border <= st1_border;
			st2_sel <= st1_sel;
			st3_rsp.user <= st2_user;
			st3_rsp.border <= st2_border;
			st3_rsp.data <= st2_border ? border_value : half;
			rsp_q <= st3_rsp;
		end
	end

	assign m_rsp = rsp_q;
	assign m_valid = rsp_valid;

	assign busy = !cke || st1_rd || st2_rd || st3_rd || rsp_valid;

	// response must sit still until taken
	assert property (@(posedge clk) disable iff (reset)
		m_valid && !m_ready |=> m_valid && $stable(m_rsp));

	// border only ever comes from the fetcher, never with a fill write
	assert property (@(posedge clk) disable iff (reset)
		s_valid && s_req.we |-> !s_req.border);

endmodule

//--- verilog/tex_cache_top.sv
`timescale 1ns/1ps

module tex_cache_top (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     endian,
	input  tex_cache_pkg::texel_t     border_value,
	input  tex_cache_pkg::tag_t       fill_tag,
	input  tex_cache_pkg::word_t      fill_data,
	input  logic                     fill_valid,
	output logic                     fill_ready,
	output logic                     line_done,
	input  tex_cache_pkg::coord_t     req_u,
	input  tex_cache_pkg::coord_t     req_v,
	input  tex_cache_pkg::user_t      req_user,
	input  logic                     req_valid,
	output logic                     req_ready,
	output tex_cache_pkg::cache_rsp_t res_rsp,
	output logic                     res_valid,
	input  logic                     res_ready,
	output logic                     busy
);
	import tex_cache_pkg::*;

	cache_req_t fill_req;
	logic fill_req_valid;
	logic fill_req_ready;

	cache_req_t fetch_req;
	logic fetch_req_valid;
	logic fetch_req_ready;

	cache_req_t mem_req;
	logic mem_valid;
	logic mem_ready;

	// ----------------------------------------
	// requesters
	// ----------------------------------------
	tex_line_fill u_fill (
		.clk        (clk),
		.reset      (reset),
		.fill_tag   (fill_tag),
		.fill_data  (fill_data),
		.fill_valid (fill_valid),
		.fill_ready (fill_ready),
		.wr_req     (fill_req),
		.wr_valid   (fill_req_valid),
		.wr_ready   (fill_req_ready),
		.line_done  (line_done)
	);

	texel_fetch u_fetch (
		.clk       (clk),
		.reset     (reset),
		.req_u     (req_u),
		.req_v     (req_v),
		.req_user  (req_user),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.rd_req    (fetch_req),
		.rd_valid  (fetch_req_valid),
		.rd_ready  (fetch_req_ready)
	);

	// shared RAM port
	tex_cache_arbiter u_arb (
		.clk         (clk),
		.reset       (reset),
		.fill_req    (fill_req),
		.fill_valid  (fill_req_valid),
		.fill_ready  (fill_req_ready),
		.fetch_req   (fetch_req),
		.fetch_valid (fetch_req_valid),
		.fetch_ready (fetch_req_ready),
		.mem_req     (mem_req),
		.mem_valid   (mem_valid),
		.mem_ready   (mem_ready)
	);

	tex_cache_mem u_mem (
		.clk          (clk),
		.reset        (reset),
		.endian       (endian),
		.border_value (border_value),
		.s_req        (mem_req),
		.s_valid      (mem_valid),
		.s_ready      (mem_ready),
		.m_rsp        (res_rsp),
		.m_valid      (res_valid),
		.m_ready      (res_ready),
		.busy         (busy)
	);

endmodule

//--- verif/tex_cache_clock.sv
`timescale 1ns/1ps

module tex_cache_clock (
	output logic clk,
	output logic reset
);
	localparam int HALF_PERIOD = 20;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// reset held for ten rising edges, released between edges
	initial begin
		reset = 1'b1;
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

//--- verif/tex_cache_tb.sv
`timescale 1ns/1ps

module tex_cache_tb;
	import tex_cache_pkg::*;

	localparam int TIMEOUT_CYCLES = 2000;

	logic clk;
	logic reset;
	logic endian;
	texel_t border_value;
	tag_t fill_tag;
	word_t fill_data;
	logic fill_valid;
	logic fill_ready;
	logic line_done;
	coord_t req_u;
	coord_t req_v;
	user_t req_user;
	logic req_valid;
	logic req_ready;
	cache_rsp_t res_rsp;
	logic res_valid;
	logic res_ready;
	logic busy;

	cache_rsp_t exp_q[$];
	int line_gen [0:63];
	int done_count = 0;
	logic stall_enable = 1'b0;
	user_t next_user = '0;

	tex_cache_clock u_clock (
		.clk   (clk),
		.reset (reset)
	);

	tex_cache_top dut (
		.clk          (clk),
		.reset        (reset),
		.endian       (endian),
		.border_value (border_value),
		.fill_tag     (fill_tag),
		.fill_data    (fill_data),
		.fill_valid   (fill_valid),
		.fill_ready   (fill_ready),
		.line_done    (line_done),
		.req_u        (req_u),
		.req_v        (req_v),
		.req_user     (req_user),
		.req_valid    (req_valid),
		.req_ready    (req_ready),
		.res_rsp      (res_rsp),
		.res_valid    (res_valid),
		.res_ready    (res_ready),
		.busy         (busy)
	);

	// ----------------------------------------
	// reference model
	// ----------------------------------------
	// unique texel per generation and coordinate
	function automatic texel_t texel_hash(input coord_t u, input coord_t v, input int gen);
		logic [11:0] key;
		key = {gen[1:0], v[4:0], u[4:0]};
		return {key ^ 12'ha5c, ~key};
	endfunction

	// word w of a line holds row w[2:1], columns {w[0],0} low and {w[0],1} high
	function automatic word_t fill_word(input tag_t tag, input logic [2:0] w, input int gen);
		coord_t u;
		coord_t v;
		v = {1'b0, tag[5:3], w[2:1]};
		u = {1'b0, tag[2:0], w[0], 1'b0};
		return {texel_hash(u | 6'd1, v, gen), texel_hash(u, v, gen)};
	endfunction

	function automatic texel_t expected_texel(input coord_t u, input coord_t v,
			input logic swap, input texel_t border_val, input int gen);
		if (u >= 32 || v >= 32) begin
			return border_val;
		end
		// endian high turns the odd column into the lower half
		if (swap) begin
			return texel_hash(u ^ 6'd1, v, gen);
		end
		return texel_hash(u, v, gen);
	endfunction

	// ----------------------------------------
	// failure reporting
	// ----------------------------------------
	task automatic stop_run();
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic report_failure(input string what);
		$display("%s", what);
		stop_run();
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("error: %s got 0x%0h expected 0x%0h", name, got, exp);
			stop_run();
		end
	endtask

	// ----------------------------------------
	// monitors
	// ----------------------------------------
	always @(posedge clk) begin : track_requests
		cache_rsp_t item;
		if (!reset && req_valid && req_ready) begin
			item.user = req_user;
			item.border = (req_u >= 32) || (req_v >= 32);
			item.data = expected_texel(req_u, req_v, endian, border_value,
				line_gen[{req_v[4:2], req_u[4:2]}]);
			exp_q.push_back(item);
		end
	end

	always @(posedge clk) begin : compare_responses
		cache_rsp_t expected;
		if (!reset && res_valid && res_ready) begin
			if (exp_q.size() == 0) begin
				report_failure("response arrived with no read outstanding");
			end else begin
				expected = exp_q.pop_front();
				check_value("res_rsp.user", res_rsp.user, expected.user);
				check_value("res_rsp.border", res_rsp.border, expected.border);
				check_value("res_rsp.data", res_rsp.data, expected.data);
			end
		end
	end

	always @(posedge clk) begin
		if (!reset && line_done) begin
			done_count++;
		end
	end

	// random back-pressure on the response port
	always @(negedge clk) begin
		res_ready = stall_enable ? 1'($urandom % 2) : 1'b1;
	end

	// ----------------------------------------
	// stimulus tasks
	// ----------------------------------------
	task automatic send_line(input tag_t tag, input int gen);
		int waited;
		line_gen[tag] = gen;
		for (int w = 0; w < 8; w++) begin
			fill_tag = tag;
			fill_data = fill_word(tag, w[2:0], gen);
			fill_valid = 1'b1;
			waited = 0;
			@(posedge clk);
			while (!fill_ready) begin
				waited++;
				if (waited > TIMEOUT_CYCLES) begin
					report_failure("fill beat was not accepted before the timeout");
				end
				@(posedge clk);
			end
			@(negedge clk);
		end
		fill_valid = 1'b0;
	endtask

	task automatic send_read(input coord_t u, input coord_t v);
		int waited;
		req_u = u;
		req_v = v;
		req_user = next_user;
		next_user = next_user + 1'b1;
		req_valid = 1'b1;
		waited = 0;
		@(posedge clk);
		while (!req_ready) begin
			waited++;
			if (waited > TIMEOUT_CYCLES) begin
				report_failure("read request was not accepted before the timeout");
			end
			@(posedge clk);
		end
		@(negedge clk);
		req_valid = 1'b0;
	endtask

	task automatic send_border_read();
		if ($urandom % 2) begin
			send_read(coord_t'(32 + $urandom % 32), coord_t'($urandom % 64));
		end else begin
			send_read(coord_t'($urandom % 64), coord_t'(32 + $urandom % 32));
		end
	endtask

	// all reads answered and the pipe empty
	task automatic wait_idle();
		int waited;
		waited = 0;
		@(posedge clk);
		while (busy || exp_q.size() != 0) begin
			waited++;
			if (waited > TIMEOUT_CYCLES) begin
				report_failure("DUT did not go idle before the timeout");
			end
			@(posedge clk);
		end
		@(negedge clk);
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial begin
		int seed_ret;
		int waited;
		seed_ret = $urandom(32'h5acf);
		endian = 1'b0;
		border_value = 24'hb0_4d_e7;
		fill_tag = '0;
		fill_data = '0;
		fill_valid = 1'b0;
		req_u = '0;
		req_v = '0;
		req_user = '0;
		req_valid = 1'b0;
		res_ready = 1'b1;
		for (int i = 0; i < 64; i++) begin
			line_gen[i] = 0;
		end

		waited = 0;
		@(negedge clk);
		while (reset) begin
			waited++;
			if (waited > TIMEOUT_CYCLES) begin
				report_failure("reset was never released");
			end
			@(negedge clk);
		end

		// idle after reset, then fill every line
		check_value("res_valid", res_valid, 0);
		check_value("busy", busy, 0);
		check_value("line_done", line_done, 0);
		for (int t = 0; t < 64; t++) begin
			send_line(tag_t'(t), 0);
		end
		wait_idle();
		check_value("line_done count", done_count, 64);

		for (int i = 0; i < 200; i++) begin
			send_read(coord_t'($urandom % 32), coord_t'($urandom % 32));
		end
		wait_idle();

		for (int i = 0; i < 60; i++) begin
			send_border_read();
		end
		wait_idle();

		stall_enable = 1'b1;
		for (int i = 0; i < 150; i++) begin
			if ($urandom % 4 == 0) begin
				send_border_read();
			end else begin
				send_read(coord_t'($urandom % 32), coord_t'($urandom % 32));
			end
		end
		wait_idle();
		stall_enable = 1'b0;

		// refill upper half of the texture while reading the lower half
		fork
			begin
				for (int t = 0; t < 32; t++) begin
					send_line(tag_t'(t), 1);
				end
			end
			begin
				for (int i = 0; i < 120; i++) begin
					send_read(coord_t'($urandom % 32), coord_t'(16 + $urandom % 16));
				end
			end
		join
		wait_idle();
		check_value("line_done count", done_count, 96);

		endian = 1'b1;
		for (int t = 0; t < 64; t++) begin
			send_line(tag_t'(t), 2);
		end
		wait_idle();
		check_value("line_done count", done_count, 160);
		for (int i = 0; i < 150; i++) begin
			if ($urandom % 8 == 0) begin
				send_border_read();
			end else begin
				send_read(coord_t'($urandom % 32), coord_t'($urandom % 32));
			end
		end
		wait_idle();

		$display("Test passed");
		$finish;
	end

endmodule

//--- compile.f
+incdir+verilog
verilog/tex_cache_pkg.sv
verilog/tex_line_fill.sv
verilog/texel_fetch.sv
verilog/tex_cache_arbiter.sv
verilog/tex_cache_mem.sv
verilog/tex_cache_top.sv
verif/tex_cache_clock.sv
verif/tex_cache_tb.sv

//--- Bender.yml
package:
  name: tex_cache

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/tex_cache_pkg.sv
      - verilog/tex_line_fill.sv
      - verilog/texel_fetch.sv
      - verilog/tex_cache_arbiter.sv
      - verilog/tex_cache_mem.sv
      - verilog/tex_cache_top.sv
  - target: test
    files:
      - verif/tex_cache_clock.sv
      - verif/tex_cache_tb.sv
